// File: src/i3c_tgt_cfg.svh
// I3C target configuration macros
// Widths and reserved addresses that the SDR protocol fixes

`ifndef I3C_TGT_CFG_SVH
`define I3C_TGT_CFG_SVH

// One SDR data byte
`define I3C_BYTE_W 8

// Seven-bit target address, rnw occupies the eighth bit
`define I3C_ADDR_W 7

// Reserved broadcast address, FC on the bus when followed by a write
`define I3C_BCAST_ADDR 7'h7E

`endif

// File: src/i3c_tgt_pkg.sv
// I3C target shared types
// States of the primary FSM, TX symbol opcodes and the bus and address structs

`include "i3c_tgt_cfg.svh"

package i3c_tgt_pkg;

  // Primary transaction states
  typedef enum logic [4:0] {
    Idle, RxFByte, CheckFByte, TxAckFByte, RxSByte, RxSByteRepeated, CheckSByte,
    TxAckSByte, RxPWriteData, RxPWriteTbit, TxPReadData, TxPReadTbit, Wait, DoCCC, DoneCCC
  } i3c_state_e;

  // Symbol the bus engine is asked to drive
  typedef enum logic [1:0] {TxSymNone, TxSymAck, TxSymData, TxSymTbit} tx_sym_e;

  // Bus monitor events, all single-cycle pulses
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic done;
  } bus_evt_t;

  // Request to the bus engine, bit requests use value[0] only
  typedef struct packed {
    logic                   req_byte;
    logic                   req_bit;
    logic [`I3C_BYTE_W-1:0] value;
  } bus_tx_req_t;

  // Static and dynamic address of one target
  typedef struct packed {
    logic [`I3C_ADDR_W-1:0] sta_addr;
    logic                   sta_valid;
    logic [`I3C_ADDR_W-1:0] dyn_addr;
    logic                   dyn_valid;
  } addr_cfg_t;

  // Address byte as seen on the bus
  typedef struct packed {
    logic [`I3C_ADDR_W-1:0] addr;
    logic                   rnw;
  } addr_byte_t;

endpackage

// File: src/i3c_tgt_addr_match.sv
// I3C target address matcher
// Holds the received address byte and compares it against this target,
// the virtual target and the broadcast address

`timescale 1ns/1ps
`include "i3c_tgt_cfg.svh"

module i3c_tgt_addr_match import i3c_tgt_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  bus_evt_t               bus_evt_i,
  input  logic [`I3C_BYTE_W-1:0] rx_data_i,
  input  logic                   capture_i,
  input  logic                   clear_i,
  input  addr_cfg_t              own_cfg_i,
  input  addr_cfg_t              virt_cfg_i,
  output logic                   own_match_o,
  output logic                   virt_match_o,
  output logic                   bcast_match_o,
  output logic                   rnw_o,
  output addr_byte_t             last_addr_o,
  output logic                   last_addr_valid_o
);

  addr_byte_t addr_q;

  // Dynamic address wins over static when both are assigned
  function automatic logic cfg_hit(input addr_cfg_t cfg, input logic [`I3C_ADDR_W-1:0] addr);
    logic hit;
    if (cfg.dyn_valid) begin
      hit = (cfg.dyn_addr == addr);
    end else if (cfg.sta_valid) begin
      hit = (cfg.sta_addr == addr);
    end else begin
      hit = 1'b0;
    end
    return hit;
  endfunction

  // Capture has priority, clear holds the register at zero while idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (capture_i) begin
      addr_q <= rx_data_i;
    end else if (clear_i) begin
      addr_q <= '0;
    end
  end

  // Valid until the next start or repeated start
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_addr_valid_o <= 1'b0;
    end else if (bus_evt_i.start || bus_evt_i.rstart) begin
      last_addr_valid_o <= 1'b0;
    end else if (capture_i) begin
      last_addr_valid_o <= 1'b1;
    end
  end

  assign own_match_o   = cfg_hit(own_cfg_i, addr_q.addr);
  assign virt_match_o  = cfg_hit(virt_cfg_i, addr_q.addr);
  // Broadcast only counts with a write, i.e. byte FC
  assign bcast_match_o = (addr_q.addr == `I3C_BCAST_ADDR) && !addr_q.rnw;
  assign rnw_o         = addr_q.rnw;
  assign last_addr_o   = addr_q;

endmodule

// File: src/i3c_tgt_rx_path.sv
// I3C target receive path
// Keeps the last received byte, checks the T-bit as odd parity and
// pushes good bytes of a private write into the RX FIFO

`timescale 1ns/1ps
`include "i3c_tgt_cfg.svh"

module i3c_tgt_rx_path import i3c_tgt_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  bus_evt_t               bus_evt_i,
  input  logic [`I3C_BYTE_W-1:0] rx_data_i,
  input  logic                   rx_req_byte_i,
  input  logic                   rx_req_bit_i,
  input  logic                   clear_i,
  output logic                   rx_fifo_wvalid_o,
  output logic [`I3C_BYTE_W-1:0] rx_fifo_wdata_o,
  output logic                   parity_err_o
);

  logic [`I3C_BYTE_W-1:0] last_byte_q;
  logic                   err_sticky_q;
  logic                   tbit_done;
  logic                   parity_bit;
  logic                   tbit_ok;

  // Every received byte lands here, address bytes included
  always_ff @(posedge clk_i) begin
    if (bus_evt_i.done && rx_req_byte_i) begin
      last_byte_q <= rx_data_i;
    end
  end

  assign tbit_done  = bus_evt_i.done && rx_req_bit_i;
  // Odd parity over byte plus T-bit
  assign parity_bit = ^{last_byte_q, 1'b1};
  assign tbit_ok    = (rx_data_i[0] == parity_bit);

  // Once a byte was bad, drop the rest of the transfer
  assign rx_fifo_wvalid_o = tbit_done && tbit_ok && !err_sticky_q;
  assign rx_fifo_wdata_o  = last_byte_q;
  assign parity_err_o     = tbit_done && !tbit_ok;

  // Sticky error, cleared once the controller is back in idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_sticky_q <= 1'b0;
    end else if (parity_err_o) begin
      err_sticky_q <= 1'b1;
    end else if (clear_i) begin
      err_sticky_q <= 1'b0;
    end
  end

endmodule

// File: src/i3c_tgt_tx_path.sv
// I3C target transmit path
// Holds the byte popped from the TX FIFO and turns the FSM symbol opcode
// into an ACK, data or T-bit request for the bus engine

`timescale 1ns/1ps
`include "i3c_tgt_cfg.svh"

module i3c_tgt_tx_path import i3c_tgt_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  bus_evt_t               bus_evt_i,
  input  tx_sym_e                tx_sym_i,
  input  logic                   tx_pop_i,
  input  logic [`I3C_BYTE_W-1:0] tx_fifo_rdata_i,
  input  logic                   tx_last_byte_i,
  input  logic                   tx_fifo_rvalid_i,
  output bus_tx_req_t            bus_tx_req_o,
  output logic                   more_data_o
);

  logic [`I3C_BYTE_W-1:0] data_q;
  logic                   last_q;
  logic                   end_q;
  logic                   tbit_done;
  logic                   ended;

  // Byte being sent, taken in the pop cycle
  always_ff @(posedge clk_i) begin
    if (tx_pop_i) begin
      data_q <= tx_fifo_rdata_i;
    end
  end

  // Last flag travels with the byte it was popped with
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= 1'b0;
    end else if (tx_pop_i) begin
      last_q <= tx_last_byte_i;
    end
  end

  assign tbit_done = bus_evt_i.done && (tx_sym_i == TxSymTbit);

  // End of transfer, recorded at the T-bit of the final byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      end_q <= 1'b0;
    end else if (bus_evt_i.start || bus_evt_i.rstart || bus_evt_i.stop) begin
      end_q <= 1'b0;
    end else if (tbit_done) begin
      end_q <= last_q;
    end
  end

  // Include the T-bit done cycle itself, the FSM decides right there
  assign ended       = end_q || (tbit_done && last_q);
  assign more_data_o = (tx_fifo_rvalid_i || tx_last_byte_i) && !ended;

  always_comb begin
    bus_tx_req_o = '0;
    case (tx_sym_i)
      TxSymAck: begin
        // ACK is SDA low
        bus_tx_req_o.req_bit = 1'b1;
      end
      TxSymData: begin
        bus_tx_req_o.req_byte = 1'b1;
        bus_tx_req_o.value    = data_q;
      end
      TxSymTbit: begin
        // T-bit high means more data follows
        bus_tx_req_o.req_bit = 1'b1;
        bus_tx_req_o.value   = {{(`I3C_BYTE_W-1){1'b0}}, !last_q};
      end
      default: ;
    endcase
  end

endmodule

// File: src/i3c_tgt_ctrl_fsm.sv
// I3C target primary FSM
// Decodes the first bytes of each SDR transaction, runs private write and
// read loops, hands CCCs to the CCC engine and flags NACKed transactions

`timescale 1ns/1ps
`include "i3c_tgt_cfg.svh"

module i3c_tgt_ctrl_fsm import i3c_tgt_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   target_enable_i,
  input  bus_evt_t               bus_evt_i,
  input  logic [`I3C_BYTE_W-1:0] rx_data_i,
  input  logic                   own_match_i,
  input  logic                   virt_match_i,
  input  logic                   bcast_match_i,
  input  logic                   rnw_i,
  input  logic                   parity_err_i,
  input  logic                   more_data_i,
  input  logic                   ccc_done_i,
  output logic                   rx_req_byte_o,
  output logic                   rx_req_bit_o,
  output tx_sym_e                tx_sym_o,
  output logic                   tx_fifo_rready_o,
  output logic                   addr_capture_o,
  output logic                   idle_o,
  output logic [`I3C_BYTE_W-1:0] ccc_o,
  output logic                   ccc_valid_o,
  output logic                   virtual_sel_o,
  output logic                   xfer_in_progress_o,
  output logic                   event_target_nack_o,
  output logic                   target_transmitting_o
);

  i3c_state_e state_q, state_d;
  logic       evt_start;
  logic       any_hit;
  logic       in_wait_q;

  // Start and repeated start behave alike here
  assign evt_start = bus_evt_i.start || bus_evt_i.rstart;
  assign any_hit   = own_match_i || virt_match_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (target_enable_i && evt_start) state_d = RxFByte;
      end
      RxFByte: begin
        if (bus_evt_i.done) state_d = CheckFByte;
      end
      // One cycle for the matcher to settle
      CheckFByte: begin
        state_d = (bcast_match_i || any_hit) ? TxAckFByte : Wait;
      end
      TxAckFByte: begin
        if (bus_evt_i.done) begin
          if (bcast_match_i) state_d = RxSByte;
          else if (any_hit && rnw_i) state_d = TxPReadData;
          else if (any_hit) state_d = RxPWriteData;
          else state_d = Wait;
        end
      end
      // After 7E/W either a CCC code or a repeated start follows
      RxSByte: begin
        if (evt_start) state_d = RxSByteRepeated;
        else if (bus_evt_i.done) state_d = DoCCC;
      end
      RxSByteRepeated: begin
        if (bus_evt_i.done) state_d = CheckSByte;
      end
      CheckSByte: begin
        state_d = any_hit ? TxAckSByte : Wait;
      end
      TxAckSByte: begin
        if (bus_evt_i.done) state_d = rnw_i ? TxPReadData : RxPWriteData;
      end
      RxPWriteData: begin
        if (evt_start) state_d = RxFByte;
        else if (bus_evt_i.done) state_d = RxPWriteTbit;
      end
      // A bad T-bit ends our part in the transfer
      RxPWriteTbit: begin
        if (bus_evt_i.done) state_d = parity_err_i ? Wait : RxPWriteData;
      end
      TxPReadData: begin
        if (evt_start) state_d = RxFByte;
        else if (bus_evt_i.done) state_d = TxPReadTbit;
      end
      TxPReadTbit: begin
        if (evt_start) state_d = RxFByte;
        else if (bus_evt_i.done) state_d = more_data_i ? TxPReadData : Wait;
      end
      // Not for us, sit out until the next start
      Wait: begin
        if (evt_start) state_d = RxFByte;
      end
      DoCCC: begin
        if (ccc_done_i) state_d = DoneCCC;
      end
      DoneCCC: begin
        state_d = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
    // STOP wins over everything
    if (bus_evt_i.stop) state_d = Idle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Receive requests, a start cancels a pending byte
  assign rx_req_byte_o = (state_q inside {RxFByte, RxSByte, RxSByteRepeated, RxPWriteData})
                         && !evt_start;
  assign rx_req_bit_o  = (state_q == RxPWriteTbit);

  always_comb begin
    case (state_q)
      TxAckFByte, TxAckSByte: tx_sym_o = TxSymAck;
      TxPReadData:            tx_sym_o = TxSymData;
      TxPReadTbit:            tx_sym_o = TxSymTbit;
      default:                tx_sym_o = TxSymNone;
    endcase
  end

  // Address bytes only, the CCC code stays out of the matcher
  assign addr_capture_o = bus_evt_i.done && (state_q inside {RxFByte, RxSByteRepeated});

  // Pop on entry into the data state
  assign tx_fifo_rready_o = (state_d == TxPReadData) && (state_q != TxPReadData);

  // CCC code is the byte after 7E/W
  always_ff @(posedge clk_i) begin
    if ((state_q == RxSByte) && bus_evt_i.done && !evt_start) begin
      ccc_o <= rx_data_i;
    end
  end

  assign ccc_valid_o = (state_q == DoCCC);
  assign idle_o      = (state_q == Idle);

  assign target_transmitting_o =
    (state_q inside {TxAckFByte, TxAckSByte, TxPReadData, TxPReadTbit});

  // NACK event on the first Wait cycle only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_wait_q <= 1'b0;
    end else begin
      in_wait_q <= (state_q == Wait);
    end
  end

  assign event_target_nack_o = (state_q == Wait) && !in_wait_q;

  // Selection flags follow the matcher in the Check states
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      virtual_sel_o      <= 1'b0;
      xfer_in_progress_o <= 1'b0;
    end else begin
      case (state_q)
        Idle: begin
          xfer_in_progress_o <= 1'b0;
        end
        CheckFByte, CheckSByte: begin
          if (!bcast_match_i) virtual_sel_o <= virt_match_i;
          xfer_in_progress_o <= any_hit;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: src/i3c_target.sv
// I3C SDR target controller
// Connects the address matcher, the RX and TX data paths and the primary FSM

`timescale 1ns/1ps
`include "i3c_tgt_cfg.svh"

module i3c_target import i3c_tgt_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   target_enable_i,
  // Bus monitor and bit/byte engine
  input  bus_evt_t               bus_evt_i,
  input  logic [`I3C_BYTE_W-1:0] bus_rx_data_i,
  output bus_tx_req_t            bus_tx_req_o,
  output logic                   bus_rx_req_byte_o,
  output logic                   bus_rx_req_bit_o,
  // Addresses of this target and the virtual target
  input  addr_cfg_t              own_cfg_i,
  input  addr_cfg_t              virt_cfg_i,
  // RX FIFO, private write data
  output logic                   rx_fifo_wvalid_o,
  output logic [`I3C_BYTE_W-1:0] rx_fifo_wdata_o,
  // TX FIFO, private read data
  input  logic                   tx_fifo_rvalid_i,
  output logic                   tx_fifo_rready_o,
  input  logic [`I3C_BYTE_W-1:0] tx_fifo_rdata_i,
  input  logic                   tx_last_byte_i,
  // CCC engine
  output logic [`I3C_BYTE_W-1:0] ccc_o,
  output logic                   ccc_valid_o,
  input  logic                   ccc_done_i,
  // Status and events
  output addr_byte_t             last_addr_o,
  output logic                   last_addr_valid_o,
  output logic                   parity_err_o,
  output logic                   target_idle_o,
  output logic                   target_transmitting_o,
  output logic                   virtual_sel_o,
  output logic                   xfer_in_progress_o,
  output logic                   event_target_nack_o
);

  logic    own_match, virt_match, bcast_match, rnw;
  logic    addr_capture, more_data;
  tx_sym_e tx_sym;

  i3c_tgt_addr_match u_addr_match (
    .clk_i, .rst_ni, .bus_evt_i, .rx_data_i(bus_rx_data_i), .capture_i(addr_capture),
    .clear_i(target_idle_o), .own_cfg_i, .virt_cfg_i, .own_match_o(own_match),
    .virt_match_o(virt_match), .bcast_match_o(bcast_match), .rnw_o(rnw), .last_addr_o,
    .last_addr_valid_o
  );

  i3c_tgt_rx_path u_rx_path (
    .clk_i, .rst_ni, .bus_evt_i, .rx_data_i(bus_rx_data_i), .rx_req_byte_i(bus_rx_req_byte_o),
    .rx_req_bit_i(bus_rx_req_bit_o), .clear_i(target_idle_o), .rx_fifo_wvalid_o,
    .rx_fifo_wdata_o, .parity_err_o
  );

  i3c_tgt_tx_path u_tx_path (
    .clk_i, .rst_ni, .bus_evt_i, .tx_sym_i(tx_sym), .tx_pop_i(tx_fifo_rready_o),
    .tx_fifo_rdata_i, .tx_last_byte_i, .tx_fifo_rvalid_i, .bus_tx_req_o,
    .more_data_o(more_data)
  );

  i3c_tgt_ctrl_fsm u_ctrl_fsm (
    .clk_i, .rst_ni, .target_enable_i, .bus_evt_i, .rx_data_i(bus_rx_data_i),
    .own_match_i(own_match), .virt_match_i(virt_match), .bcast_match_i(bcast_match),
    .rnw_i(rnw), .parity_err_i(parity_err_o), .more_data_i(more_data), .ccc_done_i,
    .rx_req_byte_o(bus_rx_req_byte_o), .rx_req_bit_o(bus_rx_req_bit_o), .tx_sym_o(tx_sym),
    .tx_fifo_rready_o, .addr_capture_o(addr_capture), .idle_o(target_idle_o), .ccc_o,
    .ccc_valid_o, .virtual_sel_o, .xfer_in_progress_o, .event_target_nack_o,
    .target_transmitting_o
  );

endmodule

// File: tb/i3c_target_assertions.sv
// Bound checker for the I3C target
// Concurrent assertions over writes, parity, NACK, reads, CCC hand-over and STOP

`timescale 1ns/1ps
`include "i3c_tgt_cfg.svh"

module i3c_target_assertions import i3c_tgt_pkg::*; (
  input logic clk_i, rst_ni,
  input bus_evt_t bus_evt_i,
  input logic [`I3C_BYTE_W-1:0] bus_rx_data_i, rx_fifo_wdata_o, tx_fifo_rdata_i, ccc_o,
  input bus_tx_req_t bus_tx_req_o,
  input logic bus_rx_req_byte_o, bus_rx_req_bit_o, rx_fifo_wvalid_o, tx_fifo_rready_o,
  input logic tx_last_byte_i, ccc_valid_o, ccc_done_i, parity_err_o, target_idle_o,
  input logic event_target_nack_o,
  input addr_cfg_t own_cfg_i, virt_cfg_i,
  input addr_byte_t last_addr_o,
  input logic last_addr_valid_o, target_transmitting_o, virtual_sel_o, xfer_in_progress_o,
  input i3c_state_e state_i
);

  int err_count = 0;
  logic [`I3C_BYTE_W-1:0] held_q, code_q, addr_seen_q, pop_data_q;
  logic err_seen_q, nacked_q, last_pop_q, tbit_done, tbit_odd, foreign;
  logic seen_own, seen_virt;

  // Dynamic address first, static otherwise
  function automatic logic selects(input addr_cfg_t c, input logic [6:0] a);
    return c.dyn_valid ? (c.dyn_addr == a) : (c.sta_valid && c.sta_addr == a);
  endfunction

  assign tbit_done = bus_evt_i.done && bus_rx_req_bit_o;
  // Byte and T-bit together hold an odd number of ones
  assign tbit_odd  = ^{held_q, bus_rx_data_i[0]};
  assign foreign   = !selects(own_cfg_i, bus_rx_data_i[7:1]) &&
                     !selects(virt_cfg_i, bus_rx_data_i[7:1]) && (bus_rx_data_i != 8'hfc);
  assign seen_own  = selects(own_cfg_i, addr_seen_q[7:1]);
  assign seen_virt = selects(virt_cfg_i, addr_seen_q[7:1]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_seen_q <= 1'b0;
      nacked_q   <= 1'b0;
      last_pop_q <= 1'b0;
    end else begin
      if (bus_evt_i.done && bus_rx_req_byte_o) held_q <= bus_rx_data_i;
      if (tbit_done && !tbit_odd) err_seen_q <= 1'b1;
      else if (target_idle_o) err_seen_q <= 1'b0;
      if (bus_evt_i.start || bus_evt_i.rstart) nacked_q <= 1'b0;
      else if (event_target_nack_o) nacked_q <= 1'b1;
      if (tx_fifo_rready_o) last_pop_q <= tx_last_byte_i;
      if (tx_fifo_rready_o) pop_data_q <= tx_fifo_rdata_i;
      if (state_i == RxSByte && bus_evt_i.done) code_q <= bus_rx_data_i;
      // Address bytes only
      if (state_i inside {RxFByte, RxSByteRepeated} && bus_evt_i.done) begin
        addr_seen_q <= bus_rx_data_i;
      end
    end
  end

  a_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbit_done && tbit_odd && !err_seen_q |-> rx_fifo_wvalid_o && rx_fifo_wdata_o == held_q)
    else begin
      $error("error rx_fifo_wdata_o %h held %h", rx_fifo_wdata_o, held_q);
      err_count++;
    end
  a_parity: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tbit_done && !tbit_odd |-> parity_err_o)
    else begin
      $error("parity error not flagged");
      err_count++;
    end
  a_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_seen_q && !target_idle_o |-> !rx_fifo_wvalid_o)
    else begin
      $error("RX FIFO written after a parity error");
      err_count++;
    end
  a_nack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == RxFByte && bus_evt_i.done && !bus_evt_i.stop && foreign |-> ##2 event_target_nack_o)
    else begin
      $error("no NACK event for a foreign address");
      err_count++;
    end
  a_no_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    nacked_q |-> !bus_tx_req_o.req_bit)
    else begin
      $error("ACK request after a NACK");
      err_count++;
    end
  a_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_fifo_rready_o |=> bus_tx_req_o.req_byte && bus_tx_req_o.value == pop_data_q)
    else begin
      $error("error bus_tx_req_o.value %h expected %h", bus_tx_req_o.value, pop_data_q);
      err_count++;
    end
  a_tbit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == TxPReadTbit |-> bus_tx_req_o.req_bit && bus_tx_req_o.value[0] == !last_pop_q)
    else begin
      $error("error bus_tx_req_o.value %h expected %h", bus_tx_req_o.value, !last_pop_q);
      err_count++;
    end
  a_ccc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ccc_valid_o) |-> ccc_o == code_q)
    else begin
      $error("error ccc_o %h expected %h", ccc_o, code_q);
      err_count++;
    end
  a_ccc_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ccc_valid_o && !ccc_done_i && !bus_evt_i.stop |=> ccc_valid_o)
    else begin
      $error("ccc_valid_o dropped before ccc_done_i");
      err_count++;
    end
  a_stop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_evt_i.stop |=> target_idle_o && !bus_tx_req_o.req_byte && !bus_tx_req_o.req_bit
                       && !bus_rx_req_byte_o && !bus_rx_req_bit_o && !ccc_valid_o)
    else begin
      $error("target not idle one cycle after STOP");
      err_count++;
    end
  a_last_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {RxFByte, RxSByteRepeated} && bus_evt_i.done && !bus_evt_i.start
    && !bus_evt_i.rstart |=> last_addr_valid_o && last_addr_o == addr_seen_q)
    else begin
      $error("error last_addr_o %h expected %h", last_addr_o, addr_seen_q);
      err_count++;
    end
  a_addr_clr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_evt_i.start || bus_evt_i.rstart |=> !last_addr_valid_o)
    else begin
      $error("last_addr_valid_o not cleared by a start");
      err_count++;
    end
  a_transmit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    target_transmitting_o == (bus_tx_req_o.req_byte || bus_tx_req_o.req_bit))
    else begin
      $error("error target_transmitting_o %h", target_transmitting_o);
      err_count++;
    end
  // Broadcast leaves the virtual selection as it was
  a_virt_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {CheckFByte, CheckSByte} && addr_seen_q != 8'hfc |=> virtual_sel_o == seen_virt)
    else begin
      $error("error virtual_sel_o %h expected %h", virtual_sel_o, seen_virt);
      err_count++;
    end
  a_xfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {CheckFByte, CheckSByte} |=> xfer_in_progress_o == (seen_own || seen_virt))
    else begin
      $error("error xfer_in_progress_o %h expected %h", xfer_in_progress_o,
             seen_own || seen_virt);
      err_count++;
    end
  a_xfer_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    target_idle_o |=> !xfer_in_progress_o)
    else begin
      $error("xfer_in_progress_o still set after idle");
      err_count++;
    end

endmodule

bind i3c_target i3c_target_assertions u_asserts (
  .clk_i, .rst_ni, .bus_evt_i, .bus_rx_data_i, .rx_fifo_wdata_o, .tx_fifo_rdata_i, .ccc_o,
  .bus_tx_req_o, .bus_rx_req_byte_o, .bus_rx_req_bit_o, .rx_fifo_wvalid_o, .tx_fifo_rready_o,
  .tx_last_byte_i, .ccc_valid_o, .ccc_done_i, .parity_err_o, .target_idle_o,
  .event_target_nack_o, .own_cfg_i, .virt_cfg_i, .last_addr_o, .last_addr_valid_o,
  .target_transmitting_o, .virtual_sel_o, .xfer_in_progress_o,
  .state_i(u_ctrl_fsm.state_q)
);

// File: tb/tb_i3c_target.sv
// Testbench for the I3C SDR target controller
// Bus engine model, FIFO stubs and scripted write, read, NACK and CCC transactions

`timescale 1ns/1ps
`include "i3c_tgt_cfg.svh"

module tb_i3c_target import i3c_tgt_pkg::*; ();

  logic                   clk_i;
  logic                   rst_ni;
  logic                   target_enable_i;
  bus_evt_t               bus_evt;
  logic [`I3C_BYTE_W-1:0] bus_rx_data;
  bus_tx_req_t            bus_tx_req;
  logic                   rx_req_byte;
  logic                   rx_req_bit;
  addr_cfg_t              own_cfg;
  addr_cfg_t              virt_cfg;
  logic                   rx_wvalid;
  logic [`I3C_BYTE_W-1:0] rx_wdata;
  logic                   tx_rvalid;
  logic                   tx_rready;
  logic [`I3C_BYTE_W-1:0] tx_rdata;
  logic                   tx_last;
  logic [`I3C_BYTE_W-1:0] ccc_code;
  logic                   ccc_valid;
  logic                   ccc_done;
  addr_byte_t             last_addr;
  logic                   last_addr_valid;
  logic                   parity_err;
  logic                   target_idle;
  logic                   target_tx;
  logic                   virtual_sel;
  logic                   xfer_busy;
  logic                   nack_evt;
  logic [31:0]            lfsr_q;

  i3c_target u_dut (
    .clk_i, .rst_ni, .target_enable_i, .bus_evt_i(bus_evt), .bus_rx_data_i(bus_rx_data),
    .bus_tx_req_o(bus_tx_req), .bus_rx_req_byte_o(rx_req_byte), .bus_rx_req_bit_o(rx_req_bit),
    .own_cfg_i(own_cfg), .virt_cfg_i(virt_cfg), .rx_fifo_wvalid_o(rx_wvalid),
    .rx_fifo_wdata_o(rx_wdata), .tx_fifo_rvalid_i(tx_rvalid), .tx_fifo_rready_o(tx_rready),
    .tx_fifo_rdata_i(tx_rdata), .tx_last_byte_i(tx_last), .ccc_o(ccc_code),
    .ccc_valid_o(ccc_valid), .ccc_done_i(ccc_done), .last_addr_o(last_addr),
    .last_addr_valid_o(last_addr_valid), .parity_err_o(parity_err),
    .target_idle_o(target_idle), .target_transmitting_o(target_tx),
    .virtual_sel_o(virtual_sel), .xfer_in_progress_o(xfer_busy),
    .event_target_nack_o(nack_evt)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run aborted");
  endtask

  // Stops at the first failed assertion in the bound checker
  always @(negedge clk_i) begin
    if (u_dut.u_asserts.err_count != 0) abort_run("an assertion failed");
  end

  // Bus engine: wait for a request level, then end it with done after 2 to 9 cycles
  task automatic bus_symbol(input logic [`I3C_BYTE_W-1:0] data);
    int n;
    int delay;
    n = 0;
    while (!(rx_req_byte || rx_req_bit || bus_tx_req.req_byte || bus_tx_req.req_bit)) begin
      @(negedge clk_i);
      n++;
      if (n > 200) abort_run("timeout waiting for a bus request");
    end
    delay = 2 + rand_bits(3);
    repeat (delay - 1) @(negedge clk_i);
    bus_evt.done = 1'b1;
    bus_rx_data  = data;
    @(negedge clk_i);
    bus_evt.done = 1'b0;
  endtask

  task automatic send_start();
    bus_evt.start = 1'b1;
    @(negedge clk_i);
    bus_evt.start = 1'b0;
  endtask

  task automatic repeated_start();
    bus_evt.rstart = 1'b1;
    @(negedge clk_i);
    bus_evt.rstart = 1'b0;
  endtask

  task automatic send_stop();
    int n;
    bus_evt.stop = 1'b1;
    @(negedge clk_i);
    bus_evt.stop = 1'b0;
    n = 0;
    while (!target_idle) begin
      @(negedge clk_i);
      n++;
      if (n > 50) abort_run("timeout waiting for the target to go idle");
    end
    repeat (3) @(negedge clk_i);
  endtask

  // Private write to addr, one T-bit optionally corrupted
  task automatic private_write(input logic [`I3C_ADDR_W-1:0] addr, input int nbytes,
                               input int bad_idx);
    logic [31:0] r;
    send_start();
    bus_symbol({addr, 1'b0});
    bus_symbol(8'h00);
    for (int i = 0; i < nbytes; i++) begin
      r = rand_bits(8);
      bus_symbol(r[7:0]);
      // Odd parity over byte and T-bit
      bus_symbol({7'h00, (i == bad_idx) ? ^r[7:0] : ~^r[7:0]});
      if (i == bad_idx) break;
    end
    // After a bad T-bit a good byte behind a repeated start is still dropped
    if (bad_idx >= 0) begin
      repeated_start();
      bus_symbol({addr, 1'b0});
      bus_symbol(8'h00);
      r = rand_bits(8);
      bus_symbol(r[7:0]);
      bus_symbol({7'h00, ~^r[7:0]});
    end
    send_stop();
  endtask

  // Present the next TX FIFO byte, the third one is the last
  task automatic load_tx(input int idx);
    logic [31:0] r;
    r         = rand_bits(8);
    tx_rdata  = r[7:0];
    tx_last   = (idx == 2);
    tx_rvalid = (idx <= 2);
  endtask

  task automatic private_read();
    load_tx(0);
    send_start();
    bus_symbol({own_cfg.sta_addr == own_cfg.dyn_addr ? 7'h00 : own_cfg.dyn_addr, 1'b1});
    bus_symbol(8'h00);
    load_tx(1);
    for (int i = 0; i < 3; i++) begin
      bus_symbol(8'h00);
      bus_symbol(8'h00);
      load_tx(i + 2);
    end
    send_stop();
  endtask

  task automatic broadcast_ccc(input logic [`I3C_BYTE_W-1:0] code);
    int n;
    send_start();
    bus_symbol({`I3C_BCAST_ADDR, 1'b0});
    bus_symbol(8'h00);
    bus_symbol(code);
    n = 0;
    while (!ccc_valid) begin
      @(negedge clk_i);
      n++;
      if (n > 50) abort_run("timeout waiting for the CCC to be handed over");
    end
    repeat (4) @(negedge clk_i);
    ccc_done = 1'b1;
    @(negedge clk_i);
    ccc_done = 1'b0;
    send_stop();
  endtask

  initial begin
    lfsr_q          = 32'h8ffc;
    rst_ni          = 1'b0;
    target_enable_i = 1'b1;
    bus_evt         = '0;
    bus_rx_data     = '0;
    own_cfg         = '{sta_addr: 7'h21, sta_valid: 1'b1, dyn_addr: 7'h35, dyn_valid: 1'b1};
    virt_cfg        = '{sta_addr: 7'h50, sta_valid: 1'b1, dyn_addr: 7'h00, dyn_valid: 1'b0};
    tx_rvalid       = 1'b0;
    tx_rdata        = '0;
    tx_last         = 1'b0;
    ccc_done        = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    private_write(own_cfg.dyn_addr, 4, -1);
    private_write(own_cfg.dyn_addr, 4, 1);
    // Virtual target on its static address
    private_write(virt_cfg.sta_addr, 2, -1);
    // Foreign address, the target sits out until the stop
    send_start();
    bus_symbol({7'h12, 1'b0});
    repeat (6) @(negedge clk_i);
    send_stop();
    private_read();
    broadcast_ccc(8'h2a);
    repeat (5) @(negedge clk_i);
    if (u_dut.u_asserts.err_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "assertion failures seen");
    end
  end

endmodule

// File: all.f
+incdir+src
src/i3c_tgt_pkg.sv
src/i3c_tgt_addr_match.sv
src/i3c_tgt_rx_path.sv
src/i3c_tgt_tx_path.sv
src/i3c_tgt_ctrl_fsm.sv
src/i3c_target.sv
tb/i3c_target_assertions.sv
tb/tb_i3c_target.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I3C target testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_i3c_target -f all.f -o sim_tb \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
